//--- verilog/snes_glue_pkg.sv
/*
  Shared register map, widths and timing constants for the clk_74a glue.
  The reset delay is shortened to 256 cycles; hardware runs far longer.
  Register offsets are full 32-bit bridge addresses and must match exactly.
*/

`default_nettype none

package snes_glue_pkg;

  ////////////////////////////////////////////////////////////
  // bus and payload types

  typedef logic [31:0] bridge_word_t;
  typedef logic [3:0]  size_code_t;
  typedef logic [23:0] rgb_t;
  typedef logic [64:0] rtc_t;

  // bridge register offsets
  typedef enum logic [31:0] {
    REG_DOWNLOAD   = 32'h0000_0000,
    REG_ROM_SIZE   = 32'h0000_0004,
    REG_ROM_TYPE   = 32'h0000_0008,
    REG_RAM_SIZE   = 32'h0000_000C,
    REG_PAL        = 32'h0000_0010,
    REG_CORE_RESET = 32'h0000_0050,
    REG_MULTITAP   = 32'h0000_0100,
    REG_LIGHTGUN   = 32'h0000_0104,
    REG_AIM_SPEED  = 32'h0000_0108,
    REG_ASPECT     = 32'h0000_0200
  } bridge_reg_e;

  // save transfer tracking
  typedef enum logic {
    SAVE_IDLE   = 1'b0,
    SAVE_ACTIVE = 1'b1
  } save_state_e;

  ////////////////////////////////////////////////////////////
  // timing and table constants

  localparam int unsigned RESET_DELAY_CYCLES = 256;
  // must hold RESET_DELAY_CYCLES itself
  localparam int unsigned RESET_DELAY_WIDTH  = 9;

  // data slot index 1 lands at table word 3
  localparam logic [9:0]  SAVE_TABLE_ADDR    = 10'd3;
  localparam bridge_word_t SAVE_SIZE_BASE    = 32'd1024;

  // end-of-line word bits seen by the scaler
  localparam int unsigned SLOT_PAL_BIT       = 14;
  localparam int unsigned SLOT_ASPECT_BIT    = 13;

endpackage

`default_nettype wire

//--- verilog/bridge_settings_regs.sv
/*
  Settings registers written from the bridge; no read-back path.
  Only the low bits each register defines are kept.
  reset_load is combinational and valid only while bridge_wr is high.
*/

`default_nettype none

module bridge_settings_regs (
  input  wire                        clk_74a,
  input  wire                        pll_core_locked,
  input  wire                        bridge_wr,
  input  wire snes_glue_pkg::bridge_word_t bridge_addr,
  input  wire snes_glue_pkg::bridge_word_t bridge_wr_data,
  output logic                       ioctl_download,
  output logic                       pal,
  output logic                       multitap_enabled,
  output logic                       lightgun_enabled,
  output logic                       lightgun_type,
  output snes_glue_pkg::size_code_t  rom_size,
  output snes_glue_pkg::size_code_t  ram_size,
  output logic [7:0]                 rom_type,
  output logic [7:0]                 aim_speed,
  output logic                       use_4_3_video,
  output logic                       reset_load
);

  import snes_glue_pkg::*;

  // core reset holds no state here, the timer takes the strobe
  assign reset_load = bridge_wr && (bridge_addr == REG_CORE_RESET);

  ////////////////////////////////////////////////////////////
  // register decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ioctl_download   <= 1'b0;
      pal              <= 1'b0;
      multitap_enabled <= 1'b0;
      lightgun_enabled <= 1'b0;
      lightgun_type    <= 1'b0;
      rom_size         <= '0;
      ram_size         <= '0;
      rom_type         <= '0;
      aim_speed        <= '0;
      use_4_3_video    <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        REG_DOWNLOAD:  ioctl_download <= bridge_wr_data[0];
        REG_ROM_SIZE:  rom_size       <= bridge_wr_data[3:0];
        REG_ROM_TYPE:  rom_type       <= bridge_wr_data[7:0];
        REG_RAM_SIZE:  ram_size       <= bridge_wr_data[3:0];
        REG_PAL:       pal            <= bridge_wr_data[0];
        REG_MULTITAP:  multitap_enabled <= bridge_wr_data[0];
        REG_LIGHTGUN: begin
          // enable in bit 0, gun type in bit 1
          lightgun_enabled <= bridge_wr_data[0];
          lightgun_type    <= bridge_wr_data[1];
        end
        REG_AIM_SPEED: aim_speed      <= bridge_wr_data[7:0];
        REG_ASPECT:    use_4_3_video  <= bridge_wr_data[0];
        // unmapped offsets fall through untouched
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/reset_delay_timer.sv
/*
  Holds the core in reset for RESET_DELAY_CYCLES after a load strobe.
  A new load during the count restarts it from the top.
*/

`default_nettype none

module reset_delay_timer (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  reset_load,
  output logic core_reset
);

  import snes_glue_pkg::*;

  logic [RESET_DELAY_WIDTH-1:0] count;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      count <= '0;
    end else if (reset_load) begin
      count <= RESET_DELAY_WIDTH'(RESET_DELAY_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // unlocked pll also keeps the core down
  assign core_reset = !pll_core_locked || (count != '0);

endmodule

`default_nettype wire

//--- verilog/save_slot_fsm.sv
/*
  Tracks a save transfer between a data slot request and all_complete.
  Requests win over completion; only a rising all_complete ends a transfer.
  The data table word for the save slot is rewritten every cycle.
*/

`default_nettype none

module save_slot_fsm (
  input  wire                        clk_74a,
  input  wire                        pll_core_locked,
  input  wire                        request_read,
  input  wire                        request_write,
  input  wire                        all_complete,
  input  wire snes_glue_pkg::size_code_t sram_size,
  output logic                       save_download,
  output logic                       datatable_wren,
  output logic [9:0]                 datatable_addr,
  output snes_glue_pkg::bridge_word_t datatable_data
);

  import snes_glue_pkg::*;

  save_state_e state;
  logic        all_complete_prev;

  ////////////////////////////////////////////////////////////
  // transfer state

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state             <= SAVE_IDLE;
      all_complete_prev <= 1'b0;
    end else begin
      all_complete_prev <= all_complete;
      if (request_read || request_write) begin
        state <= SAVE_ACTIVE;
      end else if (all_complete && !all_complete_prev) begin
        state <= SAVE_IDLE;
      end
    end
  end

  assign save_download = (state == SAVE_ACTIVE);

  ////////////////////////////////////////////////////////////
  // save size into the data table

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      datatable_addr <= SAVE_TABLE_ADDR;
      // code 0 means the cart has no save RAM
      datatable_data <= (sram_size != '0) ? (SAVE_SIZE_BASE << sram_size) : '0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/video_out_conditioner.sv
/*
  Registers core video for the scaler with one cycle of latency.
  Syncs become single-cycle pulses on the core's rising sync edge.
  The first blank cycle after a line carries the PAL and aspect bits.
*/

`default_nettype none

module video_out_conditioner (
  input  wire                  clk_74a,
  input  wire                  pll_core_locked,
  input  wire                  core_hblank,
  input  wire                  core_vblank,
  input  wire                  core_hsync,
  input  wire                  core_vsync,
  input  wire snes_glue_pkg::rgb_t core_rgb,
  input  wire                  pal,
  input  wire                  use_4_3_video,
  output logic                 video_de,
  output logic                 video_hs,
  output logic                 video_vs,
  output snes_glue_pkg::rgb_t  video_rgb
);

  import snes_glue_pkg::*;

  logic de;
  logic de_prev;
  logic hs_prev;
  logic vs_prev;
  rgb_t slot_word;

  assign de = !(core_hblank || core_vblank);

  // end-of-line word, everything else zero
  always_comb begin
    slot_word                  = '0;
    slot_word[SLOT_PAL_BIT]    = pal;
    slot_word[SLOT_ASPECT_BIT] = use_4_3_video;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_de  <= de;
      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        // last pixel was on the previous cycle
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
      video_hs  <= core_hsync && !hs_prev;
      video_vs  <= core_vsync && !vs_prev;
      de_prev   <= de;
      hs_prev   <= core_hsync;
      vs_prev   <= core_vsync;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rtc_packer.sv
/*
  Packs the host date and time into the core's 65-bit clock word.
  The top bit toggles once for each new rtc_time value.
  Weekday is not supplied by the host and is reported as 1.
*/

`default_nettype none

module rtc_packer (
  input  wire                        clk_74a,
  input  wire                        pll_core_locked,
  input  wire snes_glue_pkg::bridge_word_t rtc_date,
  input  wire snes_glue_pkg::bridge_word_t rtc_time,
  output snes_glue_pkg::rtc_t        rtc
);

  import snes_glue_pkg::*;

  bridge_word_t prev_time;
  logic         new_rtc;

  // flip on every change so the core sees an edge
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_time <= '0;
      new_rtc   <= 1'b0;
    end else if (rtc_time != prev_time) begin
      prev_time <= rtc_time;
      new_rtc   <= !new_rtc;
    end
  end

  // toggle, pad, weekday, then year month day hour minute second
  assign rtc = {new_rtc, 8'h00, 8'h01,
                rtc_date[23:16], rtc_date[15:8], rtc_date[7:0],
                rtc_time[23:16], rtc_time[15:8], rtc_time[7:0]};

endmodule

`default_nettype wire

//--- verilog/snes_glue_top.sv
/*
  Housekeeping glue around the console core, all on clk_74a.
  Bridge writes are never refused; unmapped addresses are dropped.
  pll_core_locked low resets everything and holds core_reset high.
*/

`default_nettype none

module snes_glue_top (
  input  wire                        clk_74a,
  input  wire                        pll_core_locked,

  // bridge write port
  input  wire                        bridge_wr,
  input  wire snes_glue_pkg::bridge_word_t bridge_addr,
  input  wire snes_glue_pkg::bridge_word_t bridge_wr_data,

  // data slot levels and save size from the core
  input  wire                        request_read,
  input  wire                        request_write,
  input  wire                        all_complete,
  input  wire snes_glue_pkg::size_code_t sram_size,

  // raw core video
  input  wire                        core_hblank,
  input  wire                        core_vblank,
  input  wire                        core_hsync,
  input  wire                        core_vsync,
  input  wire snes_glue_pkg::rgb_t   core_rgb,

  // host clock
  input  wire snes_glue_pkg::bridge_word_t rtc_date,
  input  wire snes_glue_pkg::bridge_word_t rtc_time,

  // settings
  output logic                       ioctl_download,
  output logic                       pal,
  output logic                       multitap_enabled,
  output logic                       lightgun_enabled,
  output logic                       lightgun_type,
  output snes_glue_pkg::size_code_t  rom_size,
  output snes_glue_pkg::size_code_t  ram_size,
  output logic [7:0]                 rom_type,
  output logic [7:0]                 aim_speed,

  output logic                       core_reset,

  // save slot and data table
  output logic                       save_download,
  output logic                       datatable_wren,
  output logic [9:0]                 datatable_addr,
  output snes_glue_pkg::bridge_word_t datatable_data,

  // scaler video
  output logic                       video_de,
  output logic                       video_hs,
  output logic                       video_vs,
  output snes_glue_pkg::rgb_t        video_rgb,

  output snes_glue_pkg::rtc_t        rtc
);

  logic use_4_3_video;
  logic reset_load;

  bridge_settings_regs u_bridge_settings_regs (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge_wr        (bridge_wr),
    .bridge_addr      (bridge_addr),
    .bridge_wr_data   (bridge_wr_data),
    .ioctl_download   (ioctl_download),
    .pal              (pal),
    .multitap_enabled (multitap_enabled),
    .lightgun_enabled (lightgun_enabled),
    .lightgun_type    (lightgun_type),
    .rom_size         (rom_size),
    .ram_size         (ram_size),
    .rom_type         (rom_type),
    .aim_speed        (aim_speed),
    .use_4_3_video    (use_4_3_video),
    .reset_load       (reset_load)
  );

  reset_delay_timer u_reset_delay_timer (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .reset_load      (reset_load),
    .core_reset      (core_reset)
  );

  save_slot_fsm u_save_slot_fsm (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .request_read    (request_read),
    .request_write   (request_write),
    .all_complete    (all_complete),
    .sram_size       (sram_size),
    .save_download   (save_download),
    .datatable_wren  (datatable_wren),
    .datatable_addr  (datatable_addr),
    .datatable_data  (datatable_data)
  );

  video_out_conditioner u_video_out_conditioner (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .core_hblank     (core_hblank),
    .core_vblank     (core_vblank),
    .core_hsync      (core_hsync),
    .core_vsync      (core_vsync),
    .core_rgb        (core_rgb),
    .pal             (pal),
    .use_4_3_video   (use_4_3_video),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

  rtc_packer u_rtc_packer (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .rtc_date        (rtc_date),
    .rtc_time        (rtc_time),
    .rtc             (rtc)
  );

endmodule

`default_nettype wire

//--- verification/snes_glue_chk.sv
/*
  Concurrent checks bound into snes_glue_top, sampled on clk_74a.
  Sync and table rules are not checked while pll_core_locked is low.
*/

`default_nettype none

module snes_glue_chk (
  input wire                            clk_74a,
  input wire                            pll_core_locked,
  input wire                            core_reset,
  input wire                            video_hs,
  input wire                            video_vs,
  input wire                            datatable_wren,
  input wire [9:0]                      datatable_addr,
  input wire                            save_download,
  input wire snes_glue_pkg::save_state_e state
);

  import snes_glue_pkg::*;

  // number of failed assertions
  int unsigned fail_count = 0;

  // an unlocked pll always holds the core down
  core_reset_unlocked: assert property (@(posedge clk_74a) !pll_core_locked |-> core_reset)
    else begin
      $error("core_reset low while the PLL is unlocked");
      fail_count++;
    end

  hs_single_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else begin
      $error("video_hs high on two consecutive cycles");
      fail_count++;
    end

  vs_single_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else begin
      $error("video_vs high on two consecutive cycles");
      fail_count++;
    end

  table_addr_fixed: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_wren |-> (datatable_addr == SAVE_TABLE_ADDR))
    else begin
      $error("data table written at the wrong address");
      fail_count++;
    end

  idle_no_download: assert property (@(posedge clk_74a)
    (state == SAVE_IDLE) |-> !save_download)
    else begin
      $error("save_download high in the idle state");
      fail_count++;
    end

endmodule

bind snes_glue_top snes_glue_chk u_snes_glue_chk (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .core_reset      (core_reset),
  .video_hs        (video_hs),
  .video_vs        (video_vs),
  .datatable_wren  (datatable_wren),
  .datatable_addr  (datatable_addr),
  .save_download   (save_download),
  .state           (u_save_slot_fsm.state)
);

`default_nettype wire

//--- verification/snes_glue_tb.sv
/*
  Directed testbench for snes_glue_top; stops at the first error.
  Inputs change on the falling edge and outputs are read on a later one.
*/

`default_nettype none

module snes_glue_tb;

  import snes_glue_pkg::*;

  localparam int TIMEOUT_CYCLES = 1000;

  logic clk_74a, pll_core_locked, bridge_wr;
  bridge_word_t bridge_addr, bridge_wr_data, rtc_date, rtc_time;
  logic request_read, request_write, all_complete;
  size_code_t sram_size;
  logic core_hblank, core_vblank, core_hsync, core_vsync;
  rgb_t core_rgb;
  logic ioctl_download, pal, multitap_enabled, lightgun_enabled, lightgun_type;
  size_code_t rom_size, ram_size;
  logic [7:0] rom_type, aim_speed;
  logic core_reset, save_download, datatable_wren, video_de, video_hs, video_vs;
  logic [9:0] datatable_addr;
  bridge_word_t datatable_data;
  rgb_t video_rgb;
  rtc_t rtc;

  integer seed;
  int errors;

  // expected settings
  logic exp_download, exp_pal, exp_multitap, exp_gun_en, exp_gun_type, exp_aspect;
  size_code_t exp_rom_size, exp_ram_size;
  logic [7:0] exp_rom_type, exp_aim_speed;
  logic exp_toggle;

  snes_glue_top u_snes_glue_top (.*);

  initial clk_74a = 1'b0;
  always #2 clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////
  // reporting and compare tasks

  task automatic fail_now(input string msg);
    errors++;
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input bridge_word_t got, input bridge_word_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_size(input size_code_t got, input size_code_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_rtc(input rtc_t got, input rtc_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_now($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // helpers enter and leave on a falling edge

  task automatic write_reg(input bridge_word_t addr, input bridge_word_t data);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr      = 1'b0;
  endtask

  task automatic check_settings();
    check_bit(ioctl_download, exp_download, "ioctl_download");
    check_bit(pal, exp_pal, "pal");
    check_bit(multitap_enabled, exp_multitap, "multitap_enabled");
    check_bit(lightgun_enabled, exp_gun_en, "lightgun_enabled");
    check_bit(lightgun_type, exp_gun_type, "lightgun_type");
    check_size(rom_size, exp_rom_size, "rom_size");
    check_size(ram_size, exp_ram_size, "ram_size");
    check_word({24'h0, rom_type}, {24'h0, exp_rom_type}, "rom_type");
    check_word({24'h0, aim_speed}, {24'h0, exp_aim_speed}, "aim_speed");
  endtask

  task automatic wait_table_write();
    int cycles;
    cycles = 0;
    while (datatable_wren !== 1'b1) begin
      if (cycles == TIMEOUT_CYCLES)
        fail_now("Timeout: datatable_wren never rose after reset release");
      cycles++;
      @(negedge clk_74a);
    end
  endtask

  // counts falling edges seen with core_reset high
  task automatic count_reset_cycles(output int high_cycles);
    high_cycles = 0;
    while (core_reset === 1'b1) begin
      if (high_cycles == TIMEOUT_CYCLES)
        fail_now("Timeout: core_reset stayed high after a reset write");
      high_cycles++;
      @(negedge clk_74a);
    end
  endtask

  function automatic rtc_t pack_rtc(input logic toggle, input bridge_word_t date,
                                    input bridge_word_t tod);
    rtc_t w;
    w          = '0;
    w[64]      = toggle;
    w[55:48]   = 8'h01;
    w[47:24]   = date[23:0];
    w[23:0]    = tod[23:0];
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_settings();
    bridge_reg_e regs [9];
    bridge_word_t d;
    regs = '{REG_DOWNLOAD, REG_ROM_SIZE, REG_ROM_TYPE, REG_RAM_SIZE, REG_PAL,
             REG_MULTITAP, REG_LIGHTGUN, REG_AIM_SPEED, REG_ASPECT};
    foreach (regs[i]) begin
      d = $random(seed);
      write_reg(regs[i], d);
      case (regs[i])
        REG_DOWNLOAD:  exp_download  = d[0];
        REG_ROM_SIZE:  exp_rom_size  = d[3:0];
        REG_ROM_TYPE:  exp_rom_type  = d[7:0];
        REG_RAM_SIZE:  exp_ram_size  = d[3:0];
        REG_PAL:       exp_pal       = d[0];
        REG_MULTITAP:  exp_multitap  = d[0];
        REG_LIGHTGUN: begin
          exp_gun_en   = d[0];
          exp_gun_type = d[1];
        end
        REG_AIM_SPEED: exp_aim_speed = d[7:0];
        default:       exp_aspect    = d[0];
      endcase
      check_settings();
    end
    // addresses outside the map
    write_reg(32'h0000_0014, ~32'h0);
    write_reg(32'h0000_0300, ~32'h0);
    check_settings();
  endtask

  task automatic test_reset_delay();
    int high_cycles;
    check_bit(core_reset, 1'b0, "core_reset before trigger");
    write_reg(REG_CORE_RESET, 32'h1);
    count_reset_cycles(high_cycles);
    check_word(high_cycles, RESET_DELAY_CYCLES, "core_reset high cycles");
    // a second write part way through restarts the count
    write_reg(REG_CORE_RESET, 32'h1);
    repeat (100) @(negedge clk_74a);
    write_reg(REG_CORE_RESET, 32'h1);
    count_reset_cycles(high_cycles);
    check_word(high_cycles, RESET_DELAY_CYCLES, "core_reset cycles after reload");
  endtask

  task automatic save_transfer(input logic use_read);
    check_bit(save_download, 1'b0, "save_download idle");
    request_read  = use_read;
    request_write = !use_read;
    @(negedge clk_74a);
    check_bit(save_download, 1'b1, "save_download after request");
    all_complete = 1'b1;
    @(negedge clk_74a);
    check_bit(save_download, 1'b1, "save_download with complete under request");
    request_read  = 1'b0;
    request_write = 1'b0;
    @(negedge clk_74a);
    check_bit(save_download, 1'b1, "save_download with complete held");
    all_complete = 1'b0;
    @(negedge clk_74a);
    all_complete = 1'b1;
    @(negedge clk_74a);
    check_bit(save_download, 1'b0, "save_download after complete edge");
    all_complete = 1'b0;
    @(negedge clk_74a);
  endtask

  task automatic test_datatable();
    size_code_t code;
    for (int i = 0; i < 24; i++) begin
      code      = (i < 16) ? size_code_t'(i) : size_code_t'($random(seed));
      sram_size = code;
      @(negedge clk_74a);
      // 1 KB times two to the code or zero without save RAM
      check_word(datatable_data, (code == 4'd0) ? 32'd0 : (32'd1 << (10 + code)),
                 "datatable_data");
      check_word({22'h0, datatable_addr}, {22'h0, SAVE_TABLE_ADDR}, "datatable_addr");
      check_bit(datatable_wren, 1'b1, "datatable_wren");
    end
  endtask

  task automatic test_video();
    rgb_t pixel, slot_exp;
    int hs_pulses, vs_pulses;
    core_hblank = 1'b0;
    core_vblank = 1'b0;
    for (int i = 0; i < 8; i++) begin
      pixel    = rgb_t'($random(seed));
      core_rgb = pixel;
      @(negedge clk_74a);
      check_bit(video_de, 1'b1, "video_de in active line");
      check_rgb(video_rgb, pixel, "active pixel");
    end
    core_hblank = 1'b1;
    core_rgb    = rgb_t'($random(seed));
    @(negedge clk_74a);
    slot_exp                  = '0;
    slot_exp[SLOT_PAL_BIT]    = exp_pal;
    slot_exp[SLOT_ASPECT_BIT] = exp_aspect;
    check_bit(video_de, 1'b0, "video_de in blank");
    check_rgb(video_rgb, slot_exp, "end-of-line word");
    @(negedge clk_74a);
    check_rgb(video_rgb, '0, "blank after end-of-line word");
    // vertical blank alone also drops the enable
    core_hblank = 1'b0;
    core_vblank = 1'b1;
    @(negedge clk_74a);
    check_bit(video_de, 1'b0, "video_de in vertical blank");
    check_rgb(video_rgb, '0, "pixel in vertical blank");
    core_hsync = 1'b1;
    core_vsync = 1'b1;
    hs_pulses  = 0;
    vs_pulses  = 0;
    repeat (6) begin
      @(negedge clk_74a);
      hs_pulses += video_hs;
      vs_pulses += video_vs;
    end
    check_word(hs_pulses, 32'd1, "video_hs pulses");
    check_word(vs_pulses, 32'd1, "video_vs pulses");
    core_hsync = 1'b0;
    core_vsync = 1'b0;
    @(negedge clk_74a);
  endtask

  task automatic test_rtc();
    bridge_word_t tod;
    rtc_date = $random(seed);
    repeat (2) begin
      tod = $random(seed);
      if (tod == rtc_time)
        tod = tod ^ 32'h1;
      rtc_time = tod;
      #1;
      check_rtc(rtc, pack_rtc(exp_toggle, rtc_date, tod), "rtc before the edge");
      @(negedge clk_74a);
      exp_toggle = !exp_toggle;
      check_rtc(rtc, pack_rtc(exp_toggle, rtc_date, tod), "rtc after a time change");
      repeat (3) begin
        @(negedge clk_74a);
        check_rtc(rtc, pack_rtc(exp_toggle, rtc_date, tod), "rtc with time held");
      end
    end
  endtask

  initial begin
    seed = 15125;
    errors = 0;
    {pll_core_locked, bridge_wr, request_read, request_write, all_complete} = '0;
    {bridge_addr, bridge_wr_data, rtc_date, rtc_time} = '0;
    {sram_size, core_hsync, core_vsync, core_rgb} = '0;
    core_hblank = 1'b1;
    core_vblank = 1'b1;
    {exp_download, exp_pal, exp_multitap, exp_gun_en, exp_gun_type, exp_aspect} = '0;
    {exp_rom_size, exp_ram_size, exp_rom_type, exp_aim_speed, exp_toggle} = '0;
    repeat (5) @(negedge clk_74a);
    check_bit(core_reset, 1'b1, "core_reset during reset");
    check_bit(datatable_wren, 1'b0, "datatable_wren during reset");
    pll_core_locked = 1'b1;
    wait_table_write();
    test_settings();
    test_reset_delay();
    save_transfer(1'b0);
    save_transfer(1'b1);
    test_datatable();
    test_video();
    test_rtc();
    // failed assertions in the bound checker
    errors += int'(u_snes_glue_top.u_snes_glue_chk.fail_count);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failures were reported");
    end
  end

endmodule

`default_nettype wire

//--- snes_glue.f
verilog/snes_glue_pkg.sv
verilog/bridge_settings_regs.sv
verilog/reset_delay_timer.sv
verilog/save_slot_fsm.sv
verilog/video_out_conditioner.sv
verilog/rtc_packer.sv
verilog/snes_glue_top.sv
verification/snes_glue_chk.sv
verification/snes_glue_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module snes_glue_tb -f snes_glue.f &&
  ./obj_dir/Vsnes_glue_tb | tee /dev/stderr | grep -qF "Simulation finished: PASS" ||
  { echo "run_sim: simulation did not pass" >&2; exit 1; }
echo "run_sim: simulation passed"
